/* rtl/adpcma_pkg.sv */
// ADPCM-A player shared definitions
// channel index, CPU write, pipeline structs, register map
// step size and index adjust tables
`default_nettype none

package adpcma_pkg;

    typedef logic [2:0] ch_t;               // channel index

    typedef struct packed {
        logic [7:0]  addr;                  // register address
        logic [15:0] data;
    } reg_wr_t;

    // register map
    localparam logic [7:0] REG_TL          = 8'h00;  // 6-bit total level
    localparam logic [7:0] REG_KEY         = 8'h01;  // bit 7 key off, 5:0 channel mask
    localparam logic [7:0] REG_START_BASE  = 8'h10;  // + channel, 256-byte units
    localparam logic [7:0] REG_END_BASE    = 8'h18;  // + channel, last 256-byte unit
    localparam logic [7:0] REG_LVLPAN_BASE = 8'h20;  // + channel, L/R enable and level

    typedef struct packed {
        logic       valid;                  // one per slot, idle or not
        ch_t        ch;
        logic [3:0] nibble;
        logic       first;                  // restart predictor
        logic       last;                   // last slot of frame
        logic       zero;                   // idle channel, contributes nothing
    } fetch_t;

    typedef struct packed {
        logic               valid;
        ch_t                ch;
        logic               last;
        logic signed [15:0] pcm;
    } pcm_t;

    typedef struct packed {
        logic               valid;
        logic               last;
        logic signed [15:0] pcm;
    } side_t;

    typedef struct packed {
        logic signed [15:0] left;
        logic signed [15:0] right;
    } stereo_t;

    // YM2610 ADPCM-A step sizes
    localparam logic [11:0] STEP_TABLE [49] = '{
        12'd16,   12'd17,   12'd19,   12'd21,   12'd23,   12'd25,   12'd28,
        12'd31,   12'd34,   12'd37,   12'd41,   12'd45,   12'd50,   12'd55,
        12'd60,   12'd66,   12'd73,   12'd80,   12'd88,   12'd97,   12'd107,
        12'd118,  12'd130,  12'd143,  12'd157,  12'd173,  12'd190,  12'd209,
        12'd230,  12'd253,  12'd279,  12'd307,  12'd337,  12'd371,  12'd408,
        12'd449,  12'd494,  12'd544,  12'd598,  12'd658,  12'd724,  12'd796,
        12'd876,  12'd963,  12'd1060, 12'd1166, 12'd1282, 12'd1411, 12'd1552
    };

    // index step per nibble magnitude, five bits so that +9 fits
    localparam logic signed [4:0] INDEX_ADJ [8] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd5, 5'sd7, 5'sd9
    };

endpackage

`default_nettype wire

/* rtl/adpcma_ctrl.sv */
// ADPCM-A control: CPU register file, key on/off
// slot counter, per-channel nibble addresses, ROM reads and nibble pick
`timescale 1ns/100ps
`default_nettype none

module adpcma_ctrl #(
    parameter int NUM_CH = 6
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    cen,       // slot strobe
    input  wire                    wr,
    input  wire adpcma_pkg::reg_wr_t wr_req,
    input  wire [7:0]              rom_data,  // one cycle after rom_rd
    output logic                   rom_rd,
    output logic [19:0]            rom_addr,
    output adpcma_pkg::fetch_t     fetch,
    output logic [5:0]             tl,
    output logic [7:0]             lvlpan     // matches fetch.ch
);

    logic [11:0]       start_r  [NUM_CH];   // 256-byte units
    logic [11:0]       end_r    [NUM_CH];
    logic [7:0]        lvlpan_r [NUM_CH];
    logic [20:0]       naddr    [NUM_CH];   // nibble address
    logic [NUM_CH-1:0] playing;
    logic [NUM_CH-1:0] first_r;             // armed by key on
    adpcma_pkg::ch_t   slot;
    logic              slot_last;
    logic              slot_end;            // slot reads last nibble of end unit
    adpcma_pkg::ch_t   wr_ch;
    logic [4:0]        wr_grp;
    logic              wr_ch_ok;
    logic              key_on, key_off;
    logic [7:0]        key_mask;
    // slot state one cycle after cen
    logic              s1_valid;
    adpcma_pkg::ch_t   s1_ch;
    logic              s1_play, s1_first, s1_last, s1_sel;

    assign wr_ch     = wr_req.addr[2:0];
    assign wr_grp    = wr_req.addr[7:3];
    assign wr_ch_ok  = int'(wr_ch) < NUM_CH;
    assign key_on    = wr && (wr_req.addr == adpcma_pkg::REG_KEY) && !wr_req.data[7];
    assign key_off   = wr && (wr_req.addr == adpcma_pkg::REG_KEY) && wr_req.data[7];
    assign key_mask  = {wr_req.data[9:8], wr_req.data[5:0]};  // 9:8 reach channels 6 and 7
    assign slot_last = (slot == adpcma_pkg::ch_t'(NUM_CH - 1));
    assign slot_end  = (naddr[slot] == {end_r[slot], 9'h1ff});

    // address registers
    always_ff @(posedge clk) begin
        if (wr && wr_ch_ok) begin
            if (wr_grp == adpcma_pkg::REG_START_BASE[7:3])
                start_r[wr_ch] <= wr_req.data[11:0];
            if (wr_grp == adpcma_pkg::REG_END_BASE[7:3])
                end_r[wr_ch] <= wr_req.data[11:0];
        end
    end

    // nibble address counters
    always_ff @(posedge clk) begin
        if (cen && playing[slot])
            naddr[slot] <= naddr[slot] + 21'd1;
        for (int i = 0; i < NUM_CH; i++) begin
            if (key_on && key_mask[i])
                naddr[i] <= {start_r[i], 9'd0};  // start * 512
        end
    end

    // slot counter, play state, ROM read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot     <= '0;
            playing  <= '0;
            first_r  <= '0;
            tl       <= '0;
            rom_rd   <= 1'b0;
            rom_addr <= '0;
            s1_valid <= 1'b0;
            s1_ch    <= '0;
            s1_play  <= 1'b0;
            s1_first <= 1'b0;
            s1_last  <= 1'b0;
            s1_sel   <= 1'b0;
            for (int i = 0; i < NUM_CH; i++)
                lvlpan_r[i] <= '0;
        end else begin
            rom_rd   <= cen && playing[slot];
            s1_valid <= cen;
            if (cen) begin
                slot     <= slot_last ? '0 : slot + 3'd1;
                rom_addr <= naddr[slot][20:1];      // byte address
                s1_ch    <= slot;
                s1_play  <= playing[slot];
                s1_first <= first_r[slot];
                s1_last  <= slot_last;
                s1_sel   <= naddr[slot][0];         // odd nibble is the low one
                if (playing[slot]) begin
                    first_r[slot] <= 1'b0;
                    if (slot_end)
                        playing[slot] <= 1'b0;      // end unit done
                end
            end
            if (wr && wr_req.addr == adpcma_pkg::REG_TL)
                tl <= wr_req.data[5:0];
            if (wr && wr_ch_ok && wr_grp == adpcma_pkg::REG_LVLPAN_BASE[7:3])
                lvlpan_r[wr_ch] <= wr_req.data[7:0];
            for (int i = 0; i < NUM_CH; i++) begin
                if (key_on && key_mask[i]) begin
                    playing[i] <= 1'b1;
                    first_r[i] <= 1'b1;
                end else if (key_off && key_mask[i]) begin
                    playing[i] <= 1'b0;
                end
            end
        end
    end

    // nibble capture, idle slots pass a zero nibble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch  <= '0;
            lvlpan <= '0;
        end else begin
            fetch.valid <= s1_valid;
            if (s1_valid) begin
                fetch.ch     <= s1_ch;
                fetch.first  <= s1_first;
                fetch.last   <= s1_last;
                fetch.zero   <= !s1_play;
                fetch.nibble <= !s1_play ? 4'd0 : (s1_sel ? rom_data[3:0] : rom_data[7:4]);
                lvlpan       <= lvlpan_r[s1_ch];    // travels with the nibble
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/adpcma_decode.sv */
// ADPCM-A nibble decoder
// per-channel 12-bit predictor and step index, one registered stage
`timescale 1ns/100ps
`default_nettype none

module adpcma_decode #(
    parameter int NUM_CH = 6
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire adpcma_pkg::fetch_t fetch,
    output adpcma_pkg::pcm_t     pcm
);

    logic signed [11:0] pred [NUM_CH];
    logic [5:0]         idx  [NUM_CH];
    logic [2:0]         mag;
    logic signed [11:0] base_pred;
    logic [5:0]         base_idx;
    logic [11:0]        step;
    logic [15:0]        diff_full;      // (2m+1) * step
    logic signed [13:0] diff;
    logic signed [13:0] sum;
    logic signed [11:0] new_pred;
    logic signed [7:0]  idx_sum;
    logic [5:0]         new_idx;

    always_comb begin
        mag       = fetch.nibble[2:0];
        base_pred = fetch.first ? 12'sd0 : pred[fetch.ch];  // key on restarts at 0
        base_idx  = fetch.first ? 6'd0 : idx[fetch.ch];
        step      = adpcma_pkg::STEP_TABLE[base_idx];
        diff_full = {mag, 1'b1} * step;
        diff      = $signed({2'b00, diff_full[14:3]});      // /8, max 2910
        sum       = fetch.nibble[3] ? base_pred - diff : base_pred + diff;
        // clamp to 12 bits signed
        if (sum > 14'sd2047)
            new_pred = 12'sd2047;
        else if (sum < -14'sd2048)
            new_pred = -12'sd2048;
        else
            new_pred = sum[11:0];
        idx_sum = $signed({2'b00, base_idx}) + adpcma_pkg::INDEX_ADJ[mag];
        if (idx_sum < 8'sd0)
            new_idx = 6'd0;
        else if (idx_sum > 8'sd48)
            new_idx = 6'd48;            // top of step table
        else
            new_idx = idx_sum[5:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm <= '0;
            for (int i = 0; i < NUM_CH; i++) begin
                pred[i] <= '0;
                idx[i]  <= '0;
            end
        end else begin
            pcm.valid <= fetch.valid;
            if (fetch.valid) begin
                pcm.ch   <= fetch.ch;
                pcm.last <= fetch.last;
                if (fetch.zero) begin
                    pcm.pcm <= '0;      // idle, state held
                end else begin
                    pcm.pcm        <= {new_pred, 4'd0};  // x16
                    pred[fetch.ch] <= new_pred;
                    idx[fetch.ch]  <= new_idx;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/adpcma_gain.sv */
// linear total level and channel level scaling, left/right pan routing
`timescale 1ns/100ps
`default_nettype none

module adpcma_gain (
    input  wire                clk,
    input  wire                rst_n,
    input  wire adpcma_pkg::pcm_t pcm,
    input  wire [5:0]          tl,
    input  wire [7:0]          lvlpan,   // 7 left, 6 right, 4:0 level
    output adpcma_pkg::side_t  left,
    output adpcma_pkg::side_t  right
);

    logic [6:0]         tl_mul;         // 1..64
    logic [5:0]         lv_mul;         // 1..32
    logic signed [22:0] mul_tl, mul_tl_sh;
    logic signed [16:0] att_tl;
    logic signed [22:0] mul_lv, mul_lv_sh;
    logic signed [15:0] scaled;

    assign tl_mul = {1'b0, tl} + 7'd1;
    assign lv_mul = {1'b0, lvlpan[4:0]} + 6'd1;

    always_comb begin
        mul_tl    = pcm.pcm * $signed({1'b0, tl_mul});
        mul_tl_sh = mul_tl >>> 6;
        att_tl    = mul_tl_sh[16:0];
        mul_lv    = att_tl * $signed({1'b0, lv_mul});
        mul_lv_sh = mul_lv >>> 5;
        scaled    = mul_lv_sh[15:0];    // never exceeds the input range
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left  <= '0;
            right <= '0;
        end else begin
            left.valid  <= pcm.valid;
            right.valid <= pcm.valid;
            if (pcm.valid) begin
                left.last  <= pcm.last;
                right.last <= pcm.last;
                left.pcm   <= lvlpan[7] ? scaled : 16'sd0;
                right.pcm  <= lvlpan[6] ? scaled : 16'sd0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/adpcma_acc.sv */
// frame accumulator for one side
// sums all slots of a frame, saturates to 16 bits on the last slot
`timescale 1ns/100ps
`default_nettype none

module adpcma_acc (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire adpcma_pkg::side_t din,
    output logic                out_valid,
    output logic signed [15:0]  sum
);

    logic signed [19:0] run;        // room for 8 full-scale channels
    logic signed [19:0] total;
    logic signed [15:0] sat;

    assign total = run + din.pcm;

    always_comb begin
        if (total > 20'sd32767)
            sat = 16'sh7fff;
        else if (total < -20'sd32768)
            sat = -16'sd32768;      // 0x8000
        else
            sat = total[15:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run       <= '0;
            sum       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (din.valid) begin
                if (din.last) begin
                    sum       <= sat;
                    out_valid <= 1'b1;
                    run       <= '0;    // next frame
                end else begin
                    run <= total;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/adpcma_top.sv */
// ADPCM-A sample player top level
// control, decoder, gain and the two side accumulators
`timescale 1ns/100ps
`default_nettype none

module adpcma_top #(
    parameter int NUM_CH = 6
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    cen,
    input  wire                    wr,
    input  wire adpcma_pkg::reg_wr_t wr_req,
    output logic                   rom_rd,
    output logic [19:0]            rom_addr,
    input  wire [7:0]              rom_data,
    output logic                   out_valid,
    output adpcma_pkg::stereo_t    out_pcm
);

    adpcma_pkg::fetch_t fetch;
    adpcma_pkg::pcm_t   pcm;
    adpcma_pkg::side_t  side_l, side_r;
    logic [5:0]         tl, tl_d;
    logic [7:0]         lvlpan, lvlpan_d;
    logic signed [15:0] sum_l, sum_r;

    adpcma_ctrl #(.NUM_CH(NUM_CH)) ctrl_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen      (cen),
        .wr       (wr),
        .wr_req   (wr_req),
        .rom_data (rom_data),
        .rom_rd   (rom_rd),
        .rom_addr (rom_addr),
        .fetch    (fetch),
        .tl       (tl),
        .lvlpan   (lvlpan)
    );

    adpcma_decode #(.NUM_CH(NUM_CH)) decode_i (
        .clk   (clk),
        .rst_n (rst_n),
        .fetch (fetch),
        .pcm   (pcm)
    );

    // levels follow the decoder stage
    always_ff @(posedge clk) begin
        tl_d     <= tl;
        lvlpan_d <= lvlpan;
    end

    adpcma_gain gain_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .pcm    (pcm),
        .tl     (tl_d),
        .lvlpan (lvlpan_d),
        .left   (side_l),
        .right  (side_r)
    );

    adpcma_acc acc_left_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .din       (side_l),
        .out_valid (out_valid),
        .sum       (sum_l)
    );

    adpcma_acc acc_right_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .din       (side_r),
        .out_valid (),          // fires with the left one
        .sum       (sum_r)
    );

    assign out_pcm = {sum_l, sum_r};

endmodule

`default_nettype wire

/* verification/adpcma_checker.sv */
// reference model of the ADPCM-A player
// registers, nibble addresses, decode, gain, frame sums; compares rom reads and frame outputs
`timescale 1ns/100ps
`default_nettype none

module adpcma_checker #(
    parameter int NUM_CH = 6
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      cen,
    input  wire                      wr,
    input  wire adpcma_pkg::reg_wr_t wr_req,
    input  wire                      rom_rd,
    input  wire [19:0]               rom_addr,
    input  wire [7:0]                rom_data,
    input  wire                      out_valid,
    input  wire adpcma_pkg::stereo_t out_pcm
);

    int errors      = 0;
    int checks      = 0;
    int frames_seen = 0;
    int reads_seen  = 0;
    int start_u [NUM_CH];
    int end_u   [NUM_CH];
    int lvlpan  [NUM_CH];
    int naddr   [NUM_CH];                // nibble address
    int pred    [NUM_CH];
    int idx     [NUM_CH];
    bit playing [NUM_CH];
    bit first   [NUM_CH];
    int tl, slot, acc_l, acc_r;
    // slot between cen and its rom byte
    bit pend, pend_play, pend_first, pend_last, pend_odd;
    int pend_ch, pend_addr;
    int exp_l [$];
    int exp_r [$];

    function automatic int clamp(input int v, input int lo, input int hi);
        clamp = (v > hi) ? hi : ((v < lo) ? lo : v);
    endfunction

    function automatic int index_step(input int m);
        case (m)
            4:       index_step = 2;
            5:       index_step = 5;
            6:       index_step = 7;
            7:       index_step = 9;
            default: index_step = -1;    // small magnitudes shrink the step
        endcase
    endfunction

    task automatic report_value(input string sig, input logic [19:0] exp_v,
                                input logic [19:0] got_v);
        $display("FAIL %s exp 0x%0h got 0x%0h", sig, exp_v, got_v);
        errors++;
    endtask

    // everything sampled mid-cycle, away from both drive times
    always @(negedge clk) begin : model
        int nib, m, diff, a, sc, e_l, e_r;
        if (!rst_n) begin
            for (int i = 0; i < NUM_CH; i++) begin
                playing[i] = 0;
                first[i]   = 0;
                pred[i]    = 0;
                idx[i]     = 0;
                lvlpan[i]  = 0;
            end
            tl    = 0;
            slot  = 0;
            acc_l = 0;
            acc_r = 0;
            pend  = 0;
            exp_l.delete();
            exp_r.delete();
        end else begin
            // read strobe one cycle after a playing slot only
            if (rom_rd !== (pend && pend_play)) begin
                $display("rom_rd %s for channel %0d", rom_rd ? "unexpected" : "missing", pend_ch);
                errors++;
            end else if (rom_rd && rom_addr !== pend_addr[19:0]) begin
                report_value("rom_addr", pend_addr[19:0], rom_addr);
            end
            if (rom_rd === 1'b1)
                reads_seen++;
            if (out_valid === 1'b1) begin
                frames_seen++;
                if (exp_l.size() == 0) begin
                    $display("out_valid came with no frame expected");
                    errors++;
                end else begin
                    e_l = exp_l.pop_front();
                    e_r = exp_r.pop_front();
                    checks += 2;
                    if (out_pcm.left !== e_l[15:0])
                        report_value("out_pcm.left", e_l[15:0], out_pcm.left);
                    if (out_pcm.right !== e_r[15:0])
                        report_value("out_pcm.right", e_r[15:0], out_pcm.right);
                end
            end
            // decode and gain of the pending slot, rom byte is present now
            if (pend) begin
                sc = 0;
                if (pend_play) begin
                    nib = pend_odd ? rom_data[3:0] : rom_data[7:4];
                    if (pend_first) begin
                        pred[pend_ch] = 0;   // key on restart
                        idx[pend_ch]  = 0;
                    end
                    m    = nib & 7;
                    diff = ((2 * m + 1) * int'(adpcma_pkg::STEP_TABLE[idx[pend_ch]])) / 8;
                    if (nib[3])
                        diff = -diff;
                    pred[pend_ch] = clamp(pred[pend_ch] + diff, -2048, 2047);
                    idx[pend_ch]  = clamp(idx[pend_ch] + index_step(m), 0, 48);
                    a  = (pred[pend_ch] * 16 * (tl + 1)) >>> 6;
                    sc = (a * ((lvlpan[pend_ch] & 31) + 1)) >>> 5;
                end
                acc_l += lvlpan[pend_ch][7] ? sc : 0;
                acc_r += lvlpan[pend_ch][6] ? sc : 0;
                if (pend_last) begin
                    exp_l.push_back(clamp(acc_l, -32768, 32767));
                    exp_r.push_back(clamp(acc_r, -32768, 32767));
                    acc_l = 0;
                    acc_r = 0;
                end
                pend = 0;
            end
            if (cen) begin
                pend       = 1;
                pend_ch    = slot;
                pend_play  = playing[slot];
                pend_first = first[slot];
                pend_last  = (slot == NUM_CH - 1);
                pend_odd   = naddr[slot][0];
                pend_addr  = naddr[slot] >> 1;
                if (playing[slot]) begin
                    first[slot] = 0;
                    if (naddr[slot] == (end_u[slot] + 1) * 512 - 1)
                        playing[slot] = 0;   // last nibble of end unit
                    naddr[slot]++;
                end
                slot = (slot == NUM_CH - 1) ? 0 : slot + 1;
            end
            if (wr) begin
                if (wr_req.addr == adpcma_pkg::REG_TL)
                    tl = wr_req.data[5:0];
                for (int i = 0; i < NUM_CH; i++) begin
                    if (wr_req.addr == adpcma_pkg::REG_KEY && wr_req.data[i]) begin
                        if (wr_req.data[7]) begin
                            playing[i] = 0;
                        end else begin
                            naddr[i]   = start_u[i] * 512;
                            playing[i] = 1;
                            first[i]   = 1;
                        end
                    end
                    if (wr_req.addr == adpcma_pkg::REG_START_BASE + i[7:0])
                        start_u[i] = wr_req.data[11:0];
                    if (wr_req.addr == adpcma_pkg::REG_END_BASE + i[7:0])
                        end_u[i] = wr_req.data[11:0];
                    if (wr_req.addr == adpcma_pkg::REG_LVLPAN_BASE + i[7:0])
                        lvlpan[i] = wr_req.data[7:0];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_adpcma.sv */
// testbench for the ADPCM-A player
// clock, reset, ROM model, test table with stimulus loop, timeout
`timescale 1ns/100ps
`default_nettype none

module tb_adpcma;

    localparam int NUM_CH    = 6;
    localparam int NUM_TESTS = 6;

    typedef struct packed {
        logic [5:0]       key;        // key on mask
        logic [5:0][7:0]  start_u;    // 256-byte units per channel
        logic [5:0][7:0]  end_u;
        logic [5:0][7:0]  lvlpan;
        logic [5:0]       tl;
        logic [5:0]       koff;       // mask keyed off halfway or 0
        logic [15:0]      frames;
        logic [15:0]      exp_reads;  // rom_rd pulses for the whole test
    } test_t;

    logic                clk;
    logic                rst_n;
    logic                cen;
    logic                wr;
    adpcma_pkg::reg_wr_t wr_req;
    logic                rom_rd;
    logic [19:0]         rom_addr;
    logic [7:0]          rom_data;
    logic                out_valid;
    adpcma_pkg::stereo_t out_pcm;

    test_t tests [NUM_TESTS];
    string names [NUM_TESTS];
    int    cycles    = 0;
    int    limit     = 0;
    int    tb_errors = 0;
    int    failed    = 0;

    adpcma_top #(.NUM_CH(NUM_CH)) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .wr        (wr),
        .wr_req    (wr_req),
        .rom_rd    (rom_rd),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .out_valid (out_valid),
        .out_pcm   (out_pcm)
    );

    adpcma_checker #(.NUM_CH(NUM_CH)) chk_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen       (cen),
        .wr        (wr),
        .wr_req    (wr_req),
        .rom_rd    (rom_rd),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .out_valid (out_valid),
        .out_pcm   (out_pcm)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;       // 4 ns period
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        lcg = s * 32'd1103515245 + 32'd12345;
    endfunction

    // ROM byte from an LCG step on the address mixed with seed 15
    function automatic logic [7:0] rom_byte(input logic [19:0] addr);
        logic [31:0] s;
        s = lcg({12'd0, addr} ^ 32'd15);
        rom_byte = s[7:0] ^ s[23:16];    // upper bits folded into the low byte
    endfunction

    always @(posedge clk) begin
        #1;
        if (rom_rd)
            rom_data <= rom_byte(rom_addr);   // sampled on the next edge
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic write_reg(input logic [7:0] addr, input logic [15:0] data);
        @(posedge clk);
        #1;
        wr          = 1'b1;
        wr_req.addr = addr;
        wr_req.data = data;
        @(posedge clk);
        #1;
        wr = 1'b0;
    endtask

    // one cen per slot every four cycles
    task automatic run_slots(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            cen = 1'b1;
            @(posedge clk);
            #1;
            cen = 1'b0;
            repeat (2) @(posedge clk);
        end
    endtask

    task automatic run_test(input int k);
        test_t t;
        int    reads0, frames0, err0, tb0, half, errs;
        t       = tests[k];
        reads0  = chk_i.reads_seen;
        frames0 = chk_i.frames_seen;
        err0    = chk_i.errors;
        tb0     = tb_errors;
        half    = t.frames / 2;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            write_reg(adpcma_pkg::REG_START_BASE + ch[7:0], {8'd0, t.start_u[ch]});
            write_reg(adpcma_pkg::REG_END_BASE + ch[7:0], {8'd0, t.end_u[ch]});
            write_reg(adpcma_pkg::REG_LVLPAN_BASE + ch[7:0], {8'd0, t.lvlpan[ch]});
        end
        write_reg(adpcma_pkg::REG_TL, {10'd0, t.tl});
        write_reg(adpcma_pkg::REG_KEY, {10'd0, t.key});
        if (t.koff != 0) begin
            run_slots(half * NUM_CH);
            write_reg(adpcma_pkg::REG_KEY, {8'd0, 2'b10, t.koff});
            run_slots((t.frames - half) * NUM_CH);
        end else begin
            run_slots(t.frames * NUM_CH);
        end
        write_reg(adpcma_pkg::REG_KEY, 16'h00bf);   // all channels off
        repeat (12) @(posedge clk);                  // pipeline drains
        if (chk_i.frames_seen - frames0 != t.frames) begin
            $display("FAIL out_valid count exp 0x%0h got 0x%0h", t.frames,
                     chk_i.frames_seen - frames0);
            tb_errors++;
        end
        if (chk_i.reads_seen - reads0 != t.exp_reads) begin
            $display("FAIL rom_rd count exp 0x%0h got 0x%0h", t.exp_reads,
                     chk_i.reads_seen - reads0);
            tb_errors++;
        end
        errs = (chk_i.errors - err0) + (tb_errors - tb0);
        if (errs != 0)
            failed++;
        $display("test %-12s frames %0d reads %0d errors %0d %s", names[k], t.frames,
                 chk_i.reads_seen - reads0, errs, (errs == 0) ? "passed" : "failed");
    endtask

    initial begin
        rst_n    = 1'b0;
        cen      = 1'b0;
        wr       = 1'b0;
        wr_req   = '0;
        rom_data = '0;
        // key, start, end, lvlpan, tl, koff, frames, reads
        names[0] = "idle";
        tests[0] = {6'h00, 48'h0, 48'h0, 48'h0, 6'd63, 6'h00, 16'd4, 16'd0};
        names[1] = "single";
        tests[1] = {6'h01, 48'h00_00_00_00_00_01, 48'h00_00_00_00_00_01,
                    48'h00_00_00_00_00_df, 6'd63, 6'h00, 16'd40, 16'd40};
        names[2] = "pan";            // ch1 left only and ch2 right only
        tests[2] = {6'h06, 48'h00_00_00_04_03_00, 48'h00_00_00_04_03_00,
                    48'h00_00_00_50_9f_00, 6'd63, 6'h00, 16'd30, 16'd60};
        names[3] = "saturate";
        tests[3] = {6'h3f, 48'h0d_0c_0b_0a_09_08, 48'h0d_0c_0b_0a_09_08,
                    48'hdf_df_df_df_df_df, 6'd63, 6'h00, 16'd60, 16'd360};
        names[4] = "end_keyoff";     // ch0 ends at 512 nibbles and ch1 is keyed off at 265
        tests[4] = {6'h03, 48'h00_00_00_00_05_02, 48'h00_00_00_00_06_02,
                    48'h00_00_00_00_df_df, 6'd63, 6'h02, 16'd530, 16'd777};
        names[5] = "total_level";
        tests[5] = {6'h01, 48'h00_00_00_00_00_01, 48'h00_00_00_00_00_01,
                    48'h00_00_00_00_00_df, 6'd20, 6'h00, 16'd40, 16'd40};
        for (int k = 0; k < NUM_TESTS; k++)
            limit += tests[k].frames * NUM_CH * 4 + 200;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int k = 0; k < NUM_TESTS; k++)
            run_test(k);
        $display("tests %0d, failed %0d, checks %0d, errors %0d", NUM_TESTS, failed,
                 chk_i.checks, chk_i.errors + tb_errors);
        if (failed == 0 && chk_i.errors == 0 && tb_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
rtl/adpcma_pkg.sv
rtl/adpcma_ctrl.sv
rtl/adpcma_decode.sv
rtl/adpcma_gain.sv
rtl/adpcma_acc.sv
rtl/adpcma_top.sv
verification/adpcma_checker.sv
verification/tb_adpcma.sv
